// ==== include/adc_acq_defines.svh ====
`ifndef ADC_ACQ_DEFINES_SVH
`define ADC_ACQ_DEFINES_SVH

// burst geometry
`define ACQ_BURST_LEN      8      // samples per burst
`define ACQ_LANE_W         16     // bits per sample lane
`define ACQ_PRETRIG_DEPTH  64     // bursts held in the ring

// word kind, top 4 bits of the 132-bit word
`define ACQ_KIND_HEADER    4'd1
`define ACQ_KIND_DATA      4'd2

// header field lsb positions inside the 128-bit payload
`define ACQ_HDR_TAG_LSB     0     // channel tag, 16 bits
`define ACQ_HDR_FILL_LSB    16    // fill number, 24 bits
`define ACQ_HDR_TYPE_LSB    40    // fill type, 2 bits
`define ACQ_HDR_NBURST_LSB  48    // data words in waveform, 11 bits
`define ACQ_HDR_PRETRIG_LSB 64    // saturated pre-trigger, 12 bits
`define ACQ_HDR_STAMP_LSB   80    // trigger burst index, 24 bits

`endif

// ==== design/acq_data_pkg.sv ====
`include "adc_acq_defines.svh"

package acq_data_pkg;

    //////////////////////////////////////////////////////////////////////
    // sample and burst payload
    //////////////////////////////////////////////////////////////////////
    typedef logic [11:0] adc_sample_t;                            // one adc code
    typedef logic [`ACQ_BURST_LEN*`ACQ_LANE_W-1:0] burst_t;       // oldest in lane 0
    typedef logic [$bits(burst_t)+3:0] acq_word_t;                // kind over payload

    //////////////////////////////////////////////////////////////////////
    // counts and host fields
    //////////////////////////////////////////////////////////////////////
    typedef logic [23:0] burst_idx_t;      // bursts since reset, also fill number
    typedef logic [10:0] num_bursts_t;     // data words per waveform
    typedef logic [11:0] pre_trig_t;       // pre-trigger bursts
    typedef logic [15:0] channel_tag_t;    // channel identity for the header

endpackage

// ==== design/acq_ctrl_pkg.sv ====
package acq_ctrl_pkg;

    // fill controller states
    typedef enum logic [2:0] {
        ST_IDLE,        // disarmed
        ST_ARMED,       // waiting for ext_trig
        ST_WAIT_FIRST,  // request taken, waiting for trigger burst
        ST_CAPTURE,     // header out, data words counting down
        ST_ACK          // ext_done high until ext_trig falls
    } acq_state_e;

    typedef logic [1:0] fill_type_t;       // {ext_enable1, ext_enable0}

endpackage

// ==== design/adc_sample_packer.sv ====
`include "adc_acq_defines.svh"

module adc_sample_packer
    import acq_data_pkg::*;
(
    input  logic        adc_clk,
    input  logic        arst_n,
    input  adc_sample_t adc_data,     // one sample per clock
    input  logic        adc_ovr,      // over-range flag for adc_data
    output burst_t      burst_data,   // eight packed samples
    output logic        burst_valid,  // one-cycle strobe per burst
    output burst_idx_t  burst_idx     // bursts emitted since reset
);

    localparam int LW = `ACQ_LANE_W;
    localparam int BW = $bits(burst_t);
    localparam int PHW = $clog2(`ACQ_BURST_LEN);
    localparam logic [PHW-1:0] PH_LAST = PHW'(`ACQ_BURST_LEN - 1);

    logic [PHW-1:0] phase;   // sample slot within the burst
    logic [LW-1:0]  lane;    // sample + ovr, zero padded
    burst_t         shift_q;
    burst_t         shift_nxt;

    assign lane      = {{(LW - $bits(adc_sample_t) - 1){1'b0}}, adc_ovr, adc_data};
    assign shift_nxt = {lane, shift_q[BW-1:LW]};   // newest enters at the top

    // control, aligned to reset release
    always_ff @(posedge adc_clk or negedge arst_n) begin
        if (!arst_n) begin
            phase       <= '0;
            burst_valid <= 1'b0;
            burst_idx   <= '0;
        end else begin
            phase       <= phase + 1'b1;           // wraps every burst
            burst_valid <= (phase == PH_LAST);
            if (phase == PH_LAST)
                burst_idx <= burst_idx + 1'b1;
        end
    end

    // payload
    always_ff @(posedge adc_clk) begin
        shift_q <= shift_nxt;
        if (phase == PH_LAST)
            burst_data <= shift_nxt;   // eighth sample lands in lane 7
    end

endmodule

// ==== design/pretrig_buffer.sv ====
`include "adc_acq_defines.svh"

module pretrig_buffer
    import acq_data_pkg::*;
(
    input  logic      adc_clk,
    input  logic      arst_n,
    input  burst_t    burst_data,
    input  logic      burst_valid,
    input  pre_trig_t async_pre_trig,   // host value, bursts
    output burst_t    dly_data,         // burst from pre-trigger bursts back
    output logic      dly_valid
);

    localparam int PW = $clog2(`ACQ_PRETRIG_DEPTH);
    localparam pre_trig_t PT_MAX = pre_trig_t'(`ACQ_PRETRIG_DEPTH - 1);
    localparam logic [PW-1:0] CNT_MAX = PW'(`ACQ_PRETRIG_DEPTH - 1);

    burst_t        mem [`ACQ_PRETRIG_DEPTH];   // ring of bursts
    logic [PW-1:0] wr_ptr;                     // slot written by this burst
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] fill_cnt;                   // bursts written, saturating
    pre_trig_t     pt_sat;
    burst_t        rd_data;

    assign pt_sat = (async_pre_trig > PT_MAX) ? PT_MAX : async_pre_trig;
    assign rd_ptr = wr_ptr - pt_sat[PW-1:0];   // wraps around the ring

    always_comb begin
        if (pt_sat == '0)
            rd_data = burst_data;                    // no delay, pass newest
        else if (pt_sat <= pre_trig_t'(fill_cnt))
            rd_data = mem[rd_ptr];
        else
            rd_data = '0;                            // slot never written
    end

    //////////////////////////////////////////////////////////////////////
    // pointers and valid
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge adc_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            fill_cnt  <= '0;
            dly_valid <= 1'b0;
        end else begin
            dly_valid <= burst_valid;                // one cycle behind the packer
            if (burst_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (fill_cnt != CNT_MAX)
                    fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // ring memory and output register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge adc_clk) begin
        if (burst_valid) begin
            mem[wr_ptr] <= burst_data;
            dly_data    <= rd_data;                  // read before overwrite
        end
    end

endmodule

// ==== design/acq_controller.sv ====
`include "adc_acq_defines.svh"

module acq_controller
    import acq_data_pkg::*;
    import acq_ctrl_pkg::*;
(
    input  logic         adc_clk,
    input  logic         arst_n,
    input  logic         ext_enable0,          // fill type bit 0
    input  logic         ext_enable1,          // fill type bit 1
    input  logic         ext_trig,             // four-phase request
    input  channel_tag_t channel_tag,
    input  burst_idx_t   initial_fill_num,
    input  logic         initial_fill_num_wr,  // load strobe, idle only
    input  num_bursts_t  async_num_bursts,
    input  pre_trig_t    async_pre_trig,
    input  burst_t       dly_data,
    input  logic         dly_valid,
    input  burst_idx_t   burst_idx,            // one burst ahead of dly_valid
    output logic         ext_done,             // four-phase acknowledge
    output logic         ddr3_wr_en,           // acquisition mode
    output logic         adc_acq_sm_idle,
    output burst_idx_t   fill_num,
    output acq_word_t    adc_acq_out_dat,
    output logic         adc_acq_out_valid
);

    localparam pre_trig_t PT_MAX = pre_trig_t'(`ACQ_PRETRIG_DEPTH - 1);

    acq_state_e  state;
    fill_type_t  fill_type;
    fill_type_t  ftype_q;      // latched at request
    pre_trig_t   pt_sat;
    pre_trig_t   pt_q;
    num_bursts_t nb_q;
    num_bursts_t remaining;    // data words still to go
    burst_idx_t  stamp;
    burst_t      hdr_payload;
    burst_t      hold_q;       // trigger burst, sent after the header
    acq_word_t   word_q;       // registered header or first data word
    logic        word_vld_q;
    logic        first_pend;   // first data word still in hold_q
    logic        load_hdr;
    logic        load_first;
    logic        live_word;    // data word straight from dly_data

    assign fill_type  = fill_type_t'({ext_enable1, ext_enable0});
    assign pt_sat     = (async_pre_trig > PT_MAX) ? PT_MAX : async_pre_trig;
    assign stamp      = burst_idx - 1'b1;   // index of the burst on dly_data
    assign load_hdr   = (state == ST_WAIT_FIRST) && dly_valid;
    assign load_first = (state == ST_CAPTURE) && first_pend && (remaining != '0);
    assign live_word  = (state == ST_CAPTURE) && !first_pend && dly_valid &&
                        (remaining != '0);

    // header builder
    always_comb begin
        hdr_payload = '0;
        hdr_payload[`ACQ_HDR_TAG_LSB     +: $bits(channel_tag_t)] = channel_tag;
        hdr_payload[`ACQ_HDR_FILL_LSB    +: $bits(burst_idx_t)]   = fill_num;
        hdr_payload[`ACQ_HDR_TYPE_LSB    +: $bits(fill_type_t)]   = ftype_q;
        hdr_payload[`ACQ_HDR_NBURST_LSB  +: $bits(num_bursts_t)]  = nb_q;
        hdr_payload[`ACQ_HDR_PRETRIG_LSB +: $bits(pre_trig_t)]    = pt_q;
        hdr_payload[`ACQ_HDR_STAMP_LSB   +: $bits(burst_idx_t)]   = stamp;
    end

    // output word mux
    assign adc_acq_out_valid = word_vld_q | live_word;
    assign adc_acq_out_dat   = live_word ? {`ACQ_KIND_DATA, dly_data} : word_q;
    assign ddr3_wr_en        = (state != ST_IDLE);
    assign adc_acq_sm_idle   = (state == ST_IDLE);

    //////////////////////////////////////////////////////////////////////
    // arm / trigger FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge adc_clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_IDLE;
            ftype_q    <= '0;
            pt_q       <= '0;
            nb_q       <= '0;
            remaining  <= '0;
            first_pend <= 1'b0;
            word_vld_q <= 1'b0;
            ext_done   <= 1'b0;
            fill_num   <= '0;
        end else begin
            word_vld_q <= load_hdr | load_first;    // header, then first data word
            case (state)
                ST_IDLE: begin
                    if (initial_fill_num_wr)
                        fill_num <= initial_fill_num;
                    if (fill_type != '0)
                        state <= ST_ARMED;
                end
                ST_ARMED: begin
                    if (fill_type == '0) begin
                        state <= ST_IDLE;           // pending request waits
                    end else if (ext_trig) begin
                        state   <= ST_WAIT_FIRST;
                        ftype_q <= fill_type;
                        pt_q    <= pt_sat;
                        nb_q    <= async_num_bursts;
                    end
                end
                ST_WAIT_FIRST: begin
                    if (dly_valid) begin            // trigger burst
                        state      <= ST_CAPTURE;
                        remaining  <= nb_q;
                        first_pend <= 1'b1;
                    end
                end
                ST_CAPTURE: begin
                    // done goes high the cycle after the last data word
                    if (remaining == '0 || (live_word && remaining == num_bursts_t'(1))) begin
                        state      <= ST_ACK;
                        ext_done   <= 1'b1;
                        fill_num   <= fill_num + 1'b1;
                        first_pend <= 1'b0;
                    end else if (load_first) begin
                        first_pend <= 1'b0;
                        remaining  <= remaining - 1'b1;
                    end else if (live_word) begin
                        remaining  <= remaining - 1'b1;
                    end
                end
                ST_ACK: begin
                    if (!ext_trig) begin            // host dropped request
                        ext_done <= 1'b0;
                        state    <= (fill_type != '0) ? ST_ARMED : ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload words
    always_ff @(posedge adc_clk) begin
        if (load_hdr) begin
            word_q <= {`ACQ_KIND_HEADER, hdr_payload};
            hold_q <= dly_data;
        end else if (load_first) begin
            word_q <= {`ACQ_KIND_DATA, hold_q};
        end
    end

endmodule

// ==== design/adc_acq_top.sv ====
module adc_acq_top
    import acq_data_pkg::*;
(
    input  logic         adc_clk,
    input  logic         arst_n,
    input  adc_sample_t  adc_data,
    input  logic         adc_ovr,
    input  channel_tag_t channel_tag,
    input  burst_idx_t   initial_fill_num,
    input  logic         initial_fill_num_wr,
    input  logic         ext_enable0,
    input  logic         ext_enable1,
    input  logic         ext_trig,
    input  num_bursts_t  async_num_bursts,
    input  pre_trig_t    async_pre_trig,
    output logic         ext_done,
    output logic         ddr3_wr_en,
    output logic         adc_acq_sm_idle,
    output burst_idx_t   fill_num,
    output acq_word_t    adc_acq_out_dat,
    output logic         adc_acq_out_valid
);

    burst_t     burst_data;    // packer -> ring
    logic       burst_valid;
    burst_idx_t burst_idx;     // packer -> controller stamp
    burst_t     dly_data;      // ring -> controller
    logic       dly_valid;

    adc_sample_packer i_adc_sample_packer (
        .adc_clk     (adc_clk),
        .arst_n      (arst_n),
        .adc_data    (adc_data),
        .adc_ovr     (adc_ovr),
        .burst_data  (burst_data),
        .burst_valid (burst_valid),
        .burst_idx   (burst_idx)
    );

    pretrig_buffer i_pretrig_buffer (
        .adc_clk        (adc_clk),
        .arst_n         (arst_n),
        .burst_data     (burst_data),
        .burst_valid    (burst_valid),
        .async_pre_trig (async_pre_trig),
        .dly_data       (dly_data),
        .dly_valid      (dly_valid)
    );

    acq_controller i_acq_controller (
        .adc_clk             (adc_clk),
        .arst_n              (arst_n),
        .ext_enable0         (ext_enable0),
        .ext_enable1         (ext_enable1),
        .ext_trig            (ext_trig),
        .channel_tag         (channel_tag),
        .initial_fill_num    (initial_fill_num),
        .initial_fill_num_wr (initial_fill_num_wr),
        .async_num_bursts    (async_num_bursts),
        .async_pre_trig      (async_pre_trig),
        .dly_data            (dly_data),
        .dly_valid           (dly_valid),
        .burst_idx           (burst_idx),
        .ext_done            (ext_done),
        .ddr3_wr_en          (ddr3_wr_en),
        .adc_acq_sm_idle     (adc_acq_sm_idle),
        .fill_num            (fill_num),
        .adc_acq_out_dat     (adc_acq_out_dat),
        .adc_acq_out_valid   (adc_acq_out_valid)
    );

endmodule

// ==== test/adc_acq_asserts.sv ====
module adc_acq_asserts
    import acq_ctrl_pkg::*;
(
    input logic       adc_clk,
    input logic       arst_n,
    input logic       ext_trig,
    input logic       ext_done,
    input logic       ddr3_wr_en,
    input logic       adc_acq_out_valid,
    input acq_state_e state
);

    timeunit 1ns;
    timeprecision 1ps;

    // no word before a request is taken
    a_no_word_unarmed: assert property (@(posedge adc_clk) disable iff (!arst_n)
        adc_acq_out_valid |-> (state != ST_IDLE && state != ST_ARMED))
        else $error("output word while idle or armed");

    a_done_rise: assert property (@(posedge adc_clk) disable iff (!arst_n)
        $rose(ext_done) |-> $past(ext_trig))   // request held when done was set
        else $error("ext_done rose without ext_trig high");

    a_done_fall: assert property (@(posedge adc_clk) disable iff (!arst_n)
        $fell(ext_done) |-> !$past(ext_trig))
        else $error("ext_done fell before ext_trig fell");

    a_done_wr_en: assert property (@(posedge adc_clk) disable iff (!arst_n)
        ext_done |-> ddr3_wr_en)
        else $error("ext_done high with ddr3_wr_en low");

endmodule

bind acq_controller adc_acq_asserts i_adc_acq_asserts (
    .adc_clk           (adc_clk),
    .arst_n            (arst_n),
    .ext_trig          (ext_trig),
    .ext_done          (ext_done),
    .ddr3_wr_en        (ddr3_wr_en),
    .adc_acq_out_valid (adc_acq_out_valid),
    .state             (state)
);

// ==== test/adc_acq_tb.sv ====
`include "adc_acq_defines.svh"

module adc_acq_tb
    import acq_data_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_WAVES      = 12;
    localparam int NB_MAX       = 16;                      // 4 random bits plus one
    localparam int DISARM_WAVE  = 4;                       // request raised while disarmed
    localparam int DISARM_WAIT  = 40;
    localparam int WAVE_MAX_CYC = (NB_MAX + 3) * `ACQ_BURST_LEN + 24;
    localparam int CYCLE_LIMIT  = N_WAVES * WAVE_MAX_CYC + DISARM_WAIT + 200;

    logic         adc_clk;
    logic         arst_n;
    adc_sample_t  adc_data;
    logic         adc_ovr;
    channel_tag_t channel_tag;
    burst_idx_t   initial_fill_num;
    logic         initial_fill_num_wr;
    logic         ext_enable0;
    logic         ext_enable1;
    logic         ext_trig;
    num_bursts_t  async_num_bursts;
    pre_trig_t    async_pre_trig;
    logic         ext_done;
    logic         ddr3_wr_en;
    logic         adc_acq_sm_idle;
    burst_idx_t   fill_num;
    acq_word_t    adc_acq_out_dat;
    logic         adc_acq_out_valid;

    logic [31:0]  lfsr = 32'hc097;
    logic [12:0]  samples [$];         // {ovr, code} per clock since reset
    int           errors = 0;
    int           checks = 0;
    int           cycles = 0;
    logic         wave_active = 1'b0;  // words are expected
    int           words_seen = 0;      // header counts as word 0
    int           last_word_cyc = 0;
    int           req_idx = 0;         // newest burst not yet past the ring at request
    int           stamp_seen = 0;
    burst_idx_t   exp_fill = '0;
    logic [1:0]   exp_type = '0;
    num_bursts_t  exp_nb = '0;
    pre_trig_t    exp_pt = '0;         // saturated value

    adc_acq_top i_adc_acq_top (.*);

    //////////////////////////////////////////////////////////////////////
    // clock, stimulus source, sample record
    //////////////////////////////////////////////////////////////////////
    initial begin
        adc_clk = 1'b0;
        forever #5 adc_clk = ~adc_clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    always @(negedge adc_clk) begin
        adc_data <= adc_sample_t'(rand_bits(12));
        adc_ovr  <= rand_bits(1) != 0;
    end

    always @(posedge adc_clk) begin
        cycles <= cycles + 1;
        if (arst_n)
            samples.push_back({adc_ovr, adc_data});   // same edge the packer samples
    end

    //////////////////////////////////////////////////////////////////////
    // reference model and checks
    //////////////////////////////////////////////////////////////////////
    function automatic burst_t model_burst(input int b);
        burst_t      v;
        logic [12:0] s;
        v = '0;                                        // bursts before index 0
        if (b >= 0) begin
            for (int k = 0; k < `ACQ_BURST_LEN; k++) begin
                s = samples[b * `ACQ_BURST_LEN + k];
                v[k * `ACQ_LANE_W +: `ACQ_LANE_W] = {3'b000, s};   // oldest in lane 0
            end
        end
        return v;
    endfunction

    function automatic acq_word_t model_header(input int stamp);
        burst_t p;
        p = '0;
        p[`ACQ_HDR_TAG_LSB     +: 16] = channel_tag;
        p[`ACQ_HDR_FILL_LSB    +: 24] = exp_fill;
        p[`ACQ_HDR_TYPE_LSB    +: 2]  = exp_type;
        p[`ACQ_HDR_NBURST_LSB  +: 11] = exp_nb;
        p[`ACQ_HDR_PRETRIG_LSB +: 12] = exp_pt;
        p[`ACQ_HDR_STAMP_LSB   +: 24] = stamp[23:0];
        return {`ACQ_KIND_HEADER, p};
    endfunction

    task automatic check_val(input string name, input acq_word_t exp, input acq_word_t got);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, got);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error at cycle %0d: %s", cycles, what);
        end
    endtask

    // output monitor, words are stable between rising edges
    always @(negedge adc_clk) begin
        if (arst_n && adc_acq_out_valid) begin
            if (!wave_active || words_seen > int'(exp_nb)) begin
                check_true(1'b0, "output word outside a waveform");
            end else if (words_seen == 0) begin
                stamp_seen = int'(adc_acq_out_dat[`ACQ_HDR_STAMP_LSB +: 24]);
                check_true(stamp_seen >= req_idx && stamp_seen <= req_idx + 2,
                           $sformatf("stamp %0d outside request window from %0d",
                                     stamp_seen, req_idx));
                check_val("header", model_header(stamp_seen), adc_acq_out_dat);
            end else begin
                check_val($sformatf("data word %0d", words_seen - 1),
                          {`ACQ_KIND_DATA,
                           model_burst(stamp_seen - int'(exp_pt) + words_seen - 1)},
                          adc_acq_out_dat);
            end
            words_seen++;
            last_word_cyc = cycles;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // waveform sequence, four-phase host side
    //////////////////////////////////////////////////////////////////////
    task automatic run_wave(input bit disarmed);
        int         raw_pt;
        int         hold;
        logic [1:0] ftype;
        @(negedge adc_clk);
        raw_pt = int'(rand_bits(7));                   // up to 127, ring holds 63
        exp_pt = pre_trig_t'((raw_pt > `ACQ_PRETRIG_DEPTH - 1) ?
                             `ACQ_PRETRIG_DEPTH - 1 : raw_pt);
        exp_nb = num_bursts_t'(rand_bits(4) + 1);
        ftype  = 2'(rand_bits(2));
        if (ftype == 2'b00)
            ftype = 2'b01;                             // any nonzero type arms
        exp_type   = ftype;
        words_seen = 0;
        async_pre_trig   <= pre_trig_t'(raw_pt);
        async_num_bursts <= exp_nb;
        if (disarmed) begin
            {ext_enable1, ext_enable0} <= 2'b00;
            while (!adc_acq_sm_idle)
                @(negedge adc_clk);
            ext_trig <= 1'b1;                          // request stays pending
            repeat (DISARM_WAIT) begin
                @(negedge adc_clk);
                check_true(!ext_done, "ext_done rose while the controller was disarmed");
                check_true(!ddr3_wr_en, "ddr3_wr_en high while the controller was idle");
            end
            req_idx     = samples.size() / `ACQ_BURST_LEN - 1;
            wave_active = 1'b1;
            {ext_enable1, ext_enable0} <= ftype;
        end else begin
            {ext_enable1, ext_enable0} <= ftype;
            repeat (2) @(negedge adc_clk);
            req_idx     = samples.size() / `ACQ_BURST_LEN - 1;
            wave_active = 1'b1;
            ext_trig   <= 1'b1;
        end
        while (!ext_done)
            @(negedge adc_clk);
        check_val("word count", exp_nb + 1, words_seen);
        check_val("done after last word", last_word_cyc + 1, cycles);
        check_val("fill number", burst_idx_t'(exp_fill + 1'b1), fill_num);
        exp_fill = exp_fill + 1'b1;
        hold = int'(rand_bits(2));
        repeat (hold) begin
            @(negedge adc_clk);
            check_true(ext_done, "ext_done fell while ext_trig was still high");
        end
        ext_trig <= 1'b0;
        while (ext_done)
            @(negedge adc_clk);
        wave_active = 1'b0;
    endtask

    initial begin
        arst_n              = 1'b0;
        adc_data            = '0;
        adc_ovr             = 1'b0;
        channel_tag         = '0;
        initial_fill_num    = '0;
        initial_fill_num_wr = 1'b0;
        ext_enable0         = 1'b0;
        ext_enable1         = 1'b0;
        ext_trig            = 1'b0;
        async_num_bursts    = '0;
        async_pre_trig      = '0;
        repeat (8) @(negedge adc_clk);
        arst_n <= 1'b1;
        @(negedge adc_clk);
        check_val("reset outputs", 4'b0001,
                  {adc_acq_out_valid, ext_done, ddr3_wr_en, adc_acq_sm_idle});
        check_val("reset fill number", 0, fill_num);
        exp_fill             = burst_idx_t'(rand_bits(24));
        channel_tag         <= channel_tag_t'(rand_bits(16));
        initial_fill_num    <= exp_fill;
        initial_fill_num_wr <= 1'b1;                   // load while idle
        @(negedge adc_clk);
        initial_fill_num_wr <= 1'b0;
        @(negedge adc_clk);
        check_val("initial fill number", exp_fill, fill_num);
        for (int w = 0; w < N_WAVES; w++)
            run_wave(w == DISARM_WAVE);
        repeat (4) @(negedge adc_clk);
        $display("waveforms: %0d, checks: %0d, errors: %0d", N_WAVES, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // watchdog
    initial begin
        while (cycles < CYCLE_LIMIT)
            @(posedge adc_clk);
        $display("timeout: run did not complete within %0d cycles, errors: %0d",
                 CYCLE_LIMIT, errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
design/acq_data_pkg.sv
design/acq_ctrl_pkg.sv
design/adc_sample_packer.sv
design/pretrig_buffer.sv
design/acq_controller.sv
design/adc_acq_top.sv
test/adc_acq_asserts.sv
test/adc_acq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the acquisition testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module adc_acq_tb \
    -f vlog.f \
    -o adc_acq_sim

./obj_dir/adc_acq_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "run_sim: ok"
else
    echo "run_sim: failed, see sim.log"
    exit 1
fi
